/* snake_game.f */
+incdir+.
snake_geom_pkg.sv
snake_ctrl_pkg.sv
turn_request.sv
heading_ctrl.sv
snake_body.sv
fruit_ctrl.sv
game_fsm.sv
snake_game_top.sv
snake_game_sva.sv
snake_game_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module snake_game_tb -f snake_game.f \
		-Mdir obj_dir -o snake_game_sim

run: compile
	@out="$$(./obj_dir/snake_game_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* snake_game_tb.sv */
/* Snake game testbench
   Table driven moves and seeded random play checked against a reference model */

`timescale 1ns/1ps
`default_nettype none

`include "snake_game_defs.svh"

module snake_game_tb;
    import snake_geom_pkg::*;

    localparam int TICK_GAP   = 300;        // Cycles per tick to outlast any fruit retry
    localparam int RAND_MOVES = 40;
    localparam int CW[4]  = '{3, 2, 0, 1};  // Quarter turn right indexed by dir_t
    localparam int CCW[4] = '{2, 3, 1, 0};

    typedef struct {
        int btn;                            // Bit 0 is right and bit 1 is left
        int ticks;
        int exp_heading;
    } move_t;

    logic       clock_25 = 1'b0;
    logic       reset;
    logic       game_tik;
    logic       right_btn;
    logic       left_btn;
    coord_t     head_x;
    coord_t     head_y;
    coord_t     fruit_x;
    coord_t     fruit_y;
    logic [7:0] score;
    len_t       snake_length;
    dir_t       heading;
    logic       game_over;

    move_t  moves[$];
    integer seed = 32'h485896f1;
    int     errors = 0;
    longint watchdog_ns;
    bit     table_ready = 1'b0;

    // Reference model
    int m_mode;                             // 0 idle, 1 playing, 2 game over
    int m_hx, m_hy;
    int m_fx, m_fy;
    int m_len, m_score, m_dir;
    int m_bx[`LEN_MAX];
    int m_by[`LEN_MAX];

    always #20 clock_25 = ~clock_25;        // 40 ns period

    snake_game_top dut0 (.clock_25, .reset, .game_tik, .right_btn, .left_btn, .head_x,
                         .head_y, .fruit_x, .fruit_y, .score, .snake_length, .heading,
                         .game_over);

    task automatic check(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual,
                     expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock_25);
        #2;                                 // Drive and sample just after the edge
    endtask

    task automatic add_move(input int btn, input int ticks, input dir_t exp);
        moves.push_back('{btn, ticks, int'(exp)});
    endtask

    task automatic restart_model();
        m_hx    = `START_HEAD_X;
        m_hy    = `START_HEAD_Y;
        m_fx    = `START_FRUIT_X;
        m_fy    = `START_FRUIT_Y;
        m_len   = `START_LEN;
        m_score = 0;
        m_dir   = 0;                        // Right
        for (int i = 0; i < `LEN_MAX; i++) begin
            m_bx[i] = (i < `START_LEN - 1) ? `START_HEAD_X - 1 - i : `EMPTY_CELL;
            m_by[i] = (i < `START_LEN - 1) ? `START_HEAD_Y : `EMPTY_CELL;
        end
    endtask

    task automatic compare_all();
        check(int'(head_x), m_hx, "head_x");
        check(int'(head_y), m_hy, "head_y");
        check(int'(fruit_x), m_fx, "fruit_x");
        check(int'(fruit_y), m_fy, "fruit_y");
        check(int'(snake_length), m_len, "snake_length");
        check(int'(score), m_score, "score");
        check(int'(heading), m_dir, "heading");
        check(int'(game_over), int'(m_mode == 2), "game_over");
    endtask

    // Direction of travel from head against neck
    function automatic int travel_dir();
        if (m_hy == m_by[0])
            return (m_hx > m_bx[0]) ? 0 : 1;
        return (m_hy < m_by[0]) ? 2 : 3;
    endfunction

    function automatic bit model_collision();
        bit hit;
        hit = (m_dir == 0 && m_hx == `GRID_W - 1) || (m_dir == 1 && m_hx == 0)
           || (m_dir == 2 && m_hy == 0) || (m_dir == 3 && m_hy == `GRID_H - 1);
        for (int i = 0; i < m_len - 1; i++) begin
            if (m_hx == m_bx[i] && m_hy == m_by[i])
                hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic press(input int btn);
        right_btn = btn[0];
        left_btn  = btn[1];
        repeat (4) next_cycle();
        right_btn = 1'b0;
        left_btn  = 1'b0;
        repeat (4) next_cycle();            // Pulse, latch and heading settle
        if (m_mode == 2)
            m_mode = 0;                     // Game over back to idle
        else if (m_mode == 0)
            m_mode = 1;                     // Start press without a turn
        else if (btn == 1)
            m_dir = CW[travel_dir()];
        else if (btn == 2)
            m_dir = CCW[travel_dir()];
        compare_all();
    endtask

    task automatic tick();
        int waited;
        int on_snake;
        bit eaten;
        waited = 0;
        on_snake = 0;
        eaten = 1'b0;
        game_tik = 1'b1;
        next_cycle();
        game_tik = 1'b0;
        if (m_mode == 1) begin
            // Head moves or game over rises
            while (head_x == coord_t'(m_hx) && head_y == coord_t'(m_hy) && !game_over
                   && waited < 8) begin
                next_cycle();
                waited++;
            end
            if (waited >= 8) begin
                errors++;
                $display("No step and no game over after a game tick at %0t ns", $time);
            end
            if (model_collision()) begin
                m_mode = 2;
                compare_all();              // Head still where it was
                restart_model();            // Game over holds the start values
            end else begin
                eaten = (m_hx == m_fx && m_hy == m_fy);
                for (int i = m_len - 2; i > 0; i--) begin
                    m_bx[i] = m_bx[i-1];
                    m_by[i] = m_by[i-1];
                end
                m_bx[0] = m_hx;
                m_by[0] = m_hy;
                case (m_dir)
                    0:       m_hx++;
                    1:       m_hx--;
                    2:       m_hy--;
                    default: m_hy++;
                endcase
                if (eaten) begin
                    m_score = (m_score + 1) % 256;
                    if (m_len < `LEN_MAX - 1)
                        m_len++;
                end
            end
        end
        repeat (TICK_GAP - waited - 1) next_cycle();
        if (eaten) begin
            // Model takes over the new fruit once it is placed legally
            check(int'(fruit_x < `GRID_W && fruit_y < `GRID_H), 1, "fruit inside grid");
            check(int'(fruit_x == m_hx && fruit_y == m_hy), 0, "fruit on head");
            for (int i = 0; i < `LEN_MAX; i++) begin
                if (fruit_x == m_bx[i] && fruit_y == m_by[i])
                    on_snake++;
            end
            check(on_snake, 0, "fruit on body");
            m_fx = fruit_x;
            m_fy = fruit_y;
        end
        compare_all();
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("Watchdog expired, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        int total;
        int btn;
        reset     = 1'b0;
        game_tik  = 1'b0;
        right_btn = 1'b0;
        left_btn  = 1'b0;
        add_move(1, 0, dir_right);          // Start press
        add_move(1, 3, dir_down);           // Down over the fruit at (8,42)
        add_move(2, 2, dir_right);
        add_move(3, 2, dir_right);          // Both buttons cancel
        add_move(2, 1, dir_up);
        add_move(1, 1, dir_right);
        add_move(0, 110, dir_right);        // Run to x = 123
        add_move(0, 1, dir_right);          // Wall
        add_move(1, 0, dir_right);          // Back to idle
        add_move(2, 0, dir_right);          // Start again
        add_move(0, 2, dir_right);
        add_move(1, 1, dir_down);           // Tight right turns into the body
        add_move(1, 1, dir_left);
        add_move(1, 1, dir_up);
        add_move(1, 1, dir_right);
        add_move(1, 0, dir_right);
        add_move(1, 0, dir_right);
        total = RAND_MOVES * 3 + moves.size() + 10;
        foreach (moves[k])
            total += moves[k].ticks;
        watchdog_ns = longint'(total) * TICK_GAP * 40;
        table_ready = 1'b1;

        repeat (8) next_cycle();
        reset = 1'b1;
        repeat (4) next_cycle();
        restart_model();
        m_mode = 0;
        compare_all();

        foreach (moves[k]) begin
            if (moves[k].btn != 0)
                press(moves[k].btn);
            repeat (moves[k].ticks) tick();
            check(int'(heading), moves[k].exp_heading, "heading from table");
        end

        for (int n = 0; n < RAND_MOVES; n++) begin
            btn = $unsigned($random(seed)) % 4;
            if (btn != 0)
                press(btn);
            repeat (1 + $unsigned($random(seed)) % 2) tick();
        end

        $display("Run complete with %0d errors", errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* snake_game_sva.sv */
/* Snake game assertions
   Head, score, length and fruit invariants on the top level */

`timescale 1ns/1ps
`default_nettype none

`include "snake_game_defs.svh"

module snake_game_sva (
    input logic                   clock_25,
    input logic                   reset,
    input snake_geom_pkg::coord_t head_x,
    input snake_geom_pkg::coord_t head_y,
    input snake_geom_pkg::coord_t fruit_x,
    input snake_geom_pkg::coord_t fruit_y,
    input logic [7:0]             score,
    input snake_geom_pkg::len_t   snake_length,
    input logic                   game_over
);
    import snake_geom_pkg::*;

    // Body registers take their first value at the first restart
    head_in_grid: assert property (@(posedge clock_25) disable iff (!reset)
        !$isunknown({head_x, head_y})
        |-> head_x < coord_t'(`GRID_W) && head_y < coord_t'(`GRID_H))
        else $error("head outside the grid");

    // Restart values settle one cycle into game over, then hold
    over_stable: assert property (@(posedge clock_25) disable iff (!reset)
        game_over && $past(game_over) |=> $stable(score) && $stable(snake_length))
        else $error("score or length moved during game over");

    fruit_legal: assert property (@(posedge clock_25) disable iff (!reset)
        game_over |=> fruit_x < coord_t'(`GRID_W) && fruit_y < coord_t'(`GRID_H)
                      && (fruit_x != head_x || fruit_y != head_y))
        else $error("fruit misplaced during game over");

endmodule

bind snake_game_top snake_game_sva sva0 (.clock_25, .reset, .head_x, .head_y, .fruit_x,
                                         .fruit_y, .score, .snake_length, .game_over);

`default_nettype wire

/* snake_game_top.sv */
/* Snake game control core
   Joins button input, heading, body, fruit and FSM blocks */

`timescale 1ns/1ps
`default_nettype none

module snake_game_top (
    input  logic                   clock_25,
    input  logic                   reset,           // Active low
    input  logic                   game_tik,
    input  logic                   right_btn,
    input  logic                   left_btn,
    output snake_geom_pkg::coord_t head_x,
    output snake_geom_pkg::coord_t head_y,
    output snake_geom_pkg::coord_t fruit_x,
    output snake_geom_pkg::coord_t fruit_y,
    output logic [7:0]             score,
    output snake_geom_pkg::len_t   snake_length,
    output snake_geom_pkg::dir_t   heading,
    output logic                   game_over
);
    import snake_geom_pkg::*;
    import snake_ctrl_pkg::*;

    logic        start_press;
    turn_t       turn;
    logic        restart, step, eat, resample;   // FSM strobes
    coord_t      neck_x, neck_y;
    body_array_t body_x, body_y;
    logic        collision, fruit_eaten, fruit_bad;

    turn_request u_turn (.clock_25, .reset, .right_btn, .left_btn, .step, .restart,
                         .start_press, .turn);

    heading_ctrl u_heading (.clock_25, .reset, .restart, .turn, .head_x, .head_y,
                            .neck_x, .neck_y, .heading);

    snake_body u_body (.clock_25, .restart, .step, .grow(eat), .heading, .head_x, .head_y,
                       .neck_x, .neck_y, .body_x, .body_y, .snake_length, .collision);

    fruit_ctrl u_fruit (.clock_25, .reset, .restart, .eat, .resample, .head_x, .head_y,
                        .body_x, .body_y, .fruit_x, .fruit_y, .fruit_eaten, .fruit_bad,
                        .score);

    game_fsm u_fsm (.clock_25, .reset, .start_press, .game_tik, .collision, .fruit_eaten,
                    .fruit_bad, .restart, .step, .eat, .resample, .game_over);

endmodule

`default_nettype wire

/* game_fsm.sv */
/* Game state machine
   Sequences ticks into move, eat and fruit retry, issues the strobes */

`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  logic clock_25,
    input  logic reset,
    input  logic start_press,
    input  logic game_tik,
    input  logic collision,
    input  logic fruit_eaten,
    input  logic fruit_bad,
    output logic restart,
    output logic step,
    output logic eat,
    output logic resample,
    output logic game_over
);
    import snake_ctrl_pkg::*;

    game_state_t state;
    game_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            st_idle:         if (start_press) next_state = st_wait;
            st_wait:         if (game_tik) next_state = st_moving;   // Ticks elsewhere dropped
            st_moving:       next_state = st_move_done;
            st_move_done: begin
                if (collision)
                    next_state = st_collision;  // Step suppressed
                else if (fruit_eaten)
                    next_state = st_eaten;
                else
                    next_state = st_wait;
            end
            st_eaten:        next_state = st_fruit_update;   // New fruit checked there
            st_fruit_update: if (!fruit_bad) next_state = st_wait;
            st_collision:    if (start_press) next_state = st_idle;
            default:         next_state = st_idle;
        endcase
    end

    // Moore outputs registered from the next state so they line up with the state
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state     <= st_idle;
            restart   <= 1'b0;
            step      <= 1'b0;
            eat       <= 1'b0;
            resample  <= 1'b0;
            game_over <= 1'b0;
        end else begin
            state     <= next_state;
            restart   <= (next_state == st_idle) || (next_state == st_collision);
            step      <= next_state == st_move_done;
            eat       <= next_state == st_eaten;             // One cycle per fruit
            resample  <= (next_state == st_eaten) || (next_state == st_fruit_update);
            game_over <= next_state == st_collision;
        end
    end

endmodule

`default_nettype wire

/* fruit_ctrl.sv */
/* Fruit control
   Fruit position from two LFSRs with placement retry, eaten test and score */

`timescale 1ns/1ps
`default_nettype none

`include "snake_game_defs.svh"

module fruit_ctrl (
    input  logic                        clock_25,
    input  logic                        reset,
    input  logic                        restart,
    input  logic                        eat,
    input  logic                        resample,
    input  snake_geom_pkg::coord_t      head_x,
    input  snake_geom_pkg::coord_t      head_y,
    input  snake_geom_pkg::body_array_t body_x,
    input  snake_geom_pkg::body_array_t body_y,
    output snake_geom_pkg::coord_t      fruit_x,
    output snake_geom_pkg::coord_t      fruit_y,
    output logic                        fruit_eaten,
    output logic                        fruit_bad,
    output logic [7:0]                  score
);
    import snake_geom_pkg::*;

    coord_t lfsr_x;
    coord_t lfsr_y;
    logic   on_body;

    // x^7 + x^6 + 1, full 127 state cycle
    function automatic coord_t lfsr_next(input coord_t q);
        return {q[5:0], q[6] ^ q[5]};
    endfunction

    // Free running, so each retry sees a fresh pair
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr_x <= `SEED_X;
            lfsr_y <= `SEED_Y;
        end else begin
            lfsr_x <= lfsr_next(lfsr_x);
            lfsr_y <= lfsr_next(lfsr_y);
        end
    end

    // Empty slots hold an off-grid cell, so all slots can be scanned
    always_comb begin
        on_body = 1'b0;
        for (int i = 0; i < `LEN_MAX; i++) begin
            if (fruit_x == body_x[i] && fruit_y == body_y[i])
                on_body = 1'b1;
        end
    end

    assign fruit_eaten = (fruit_x == head_x) && (fruit_y == head_y);
    assign fruit_bad   = fruit_x >= coord_t'(`GRID_W) || fruit_y >= coord_t'(`GRID_H)
                      || fruit_eaten || on_body;

    // After the first load only a bad fruit is replaced, a good one is kept
    always_ff @(posedge clock_25) begin
        if (restart) begin
            fruit_x <= coord_t'(`START_FRUIT_X);
            fruit_y <= coord_t'(`START_FRUIT_Y);
        end else if (resample && (eat || fruit_bad)) begin
            fruit_x <= lfsr_x;
            fruit_y <= lfsr_y;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            score <= 8'd0;
        else if (restart)
            score <= 8'd0;
        else if (eat)
            score <= score + 8'd1;          // Wraps at 255
    end

endmodule

`default_nettype wire

/* snake_body.sv */
/* Snake body
   Head and body shift register, length count, wall and self collision */

`timescale 1ns/1ps
`default_nettype none

`include "snake_game_defs.svh"

module snake_body (
    input  logic                        clock_25,
    input  logic                        restart,
    input  logic                        step,
    input  logic                        grow,
    input  snake_geom_pkg::dir_t        heading,
    output snake_geom_pkg::coord_t      head_x,
    output snake_geom_pkg::coord_t      head_y,
    output snake_geom_pkg::coord_t      neck_x,
    output snake_geom_pkg::coord_t      neck_y,
    output snake_geom_pkg::body_array_t body_x,
    output snake_geom_pkg::body_array_t body_y,
    output snake_geom_pkg::len_t        snake_length,
    output logic                        collision
);
    import snake_geom_pkg::*;

    coord_t next_x;                         // Head after one step
    coord_t next_y;
    logic   self_hit;
    logic   wall_hit;

    assign neck_x = body_x[0];
    assign neck_y = body_y[0];

    // One cell along the heading
    always_comb begin
        next_x = head_x;
        next_y = head_y;
        case (heading)
            dir_right: next_x = head_x + 7'd1;
            dir_left:  next_x = head_x - 7'd1;
            dir_up:    next_y = head_y - 7'd1;
            default:   next_y = head_y + 7'd1;
        endcase
    end

    // Head sitting on a live body slot
    always_comb begin
        self_hit = 1'b0;
        for (int i = 0; i < `LEN_MAX; i++) begin
            if (i < int'(snake_length) - 1 && head_x == body_x[i] && head_y == body_y[i])
                self_hit = 1'b1;
        end
    end

    // Next step would leave the grid
    assign wall_hit = (head_x == 7'd0 && heading == dir_left)
                   || (head_x == coord_t'(`GRID_W - 1) && heading == dir_right)
                   || (head_y == 7'd0 && heading == dir_up)
                   || (head_y == coord_t'(`GRID_H - 1) && heading == dir_down);

    assign collision = self_hit | wall_hit;

    // Start values load while the FSM sits in idle or game over
    always_ff @(posedge clock_25) begin
        if (restart) begin
            head_x <= coord_t'(`START_HEAD_X);
            head_y <= coord_t'(`START_HEAD_Y);
            for (int i = 0; i < `LEN_MAX; i++) begin
                if (i < `START_LEN - 1) begin
                    body_x[i] <= coord_t'(`START_HEAD_X - 1 - i);  // Trail to the left
                    body_y[i] <= coord_t'(`START_HEAD_Y);
                end else begin
                    body_x[i] <= coord_t'(`EMPTY_CELL);
                    body_y[i] <= coord_t'(`EMPTY_CELL);
                end
            end
            snake_length <= len_t'(`START_LEN);
        end else begin
            if (step && !collision) begin
                head_x    <= next_x;
                head_y    <= next_y;
                body_x[0] <= head_x;                // Neck takes the old head
                body_y[0] <= head_y;
                // Shift only the live part so a grown tail slot fills on the next step
                for (int i = 1; i < `LEN_MAX; i++) begin
                    if (i < int'(snake_length) - 1) begin
                        body_x[i] <= body_x[i-1];
                        body_y[i] <= body_y[i-1];
                    end
                end
            end
            if (grow && snake_length != len_t'(`LEN_MAX - 1))
                snake_length <= snake_length + 1'b1;   // Saturates at 15
        end
    end

endmodule

`default_nettype wire

/* heading_ctrl.sv */
/* Heading control
   Turns the heading a quarter turn relative to the head to neck direction */

`timescale 1ns/1ps
`default_nettype none

module heading_ctrl (
    input  logic                   clock_25,
    input  logic                   reset,
    input  logic                   restart,
    input  snake_ctrl_pkg::turn_t  turn,
    input  snake_geom_pkg::coord_t head_x,
    input  snake_geom_pkg::coord_t head_y,
    input  snake_geom_pkg::coord_t neck_x,
    input  snake_geom_pkg::coord_t neck_y,
    output snake_geom_pkg::dir_t   heading
);
    import snake_geom_pkg::*;
    import snake_ctrl_pkg::*;

    dir_t travel;                           // Direction the snake actually moved
    dir_t turned;

    // Travel direction from the geometry, not from the heading register
    always_comb begin
        travel = heading;                   // Degenerate geometry keeps heading
        if (head_y == neck_y && head_x > neck_x)
            travel = dir_right;
        else if (head_y == neck_y && head_x < neck_x)
            travel = dir_left;
        else if (head_x == neck_x && head_y < neck_y)
            travel = dir_up;
        else if (head_x == neck_x && head_y > neck_y)
            travel = dir_down;
    end

    // Right is clockwise on screen, y grows downward
    always_comb begin
        case (travel)
            dir_right: turned = (turn == turn_right) ? dir_down  : dir_up;
            dir_down:  turned = (turn == turn_right) ? dir_left  : dir_right;
            dir_left:  turned = (turn == turn_right) ? dir_up    : dir_down;
            default:   turned = (turn == turn_right) ? dir_right : dir_left;
        endcase
    end

    // Same result on every cycle the turn stays pending
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            heading <= dir_right;
        else if (restart)
            heading <= dir_right;
        else if (turn != turn_none)
            heading <= turned;
    end

endmodule

`default_nettype wire

/* turn_request.sv */
/* Button edge detection and turn latch
   Gives a start pulse on any press and holds the turn until the next step */

`timescale 1ns/1ps
`default_nettype none

module turn_request (
    input  logic                  clock_25,
    input  logic                  reset,
    input  logic                  right_btn,
    input  logic                  left_btn,
    input  logic                  step,
    input  logic                  restart,
    output logic                  start_press,
    output snake_ctrl_pkg::turn_t turn
);
    import snake_ctrl_pkg::*;

    logic [1:0] right_shift;                // [0] newest sample
    logic [1:0] left_shift;
    logic       right_pulse;
    logic       left_pulse;

    // Sample buttons and register the rising edges
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            right_shift <= 2'b00;
            left_shift  <= 2'b00;
            right_pulse <= 1'b0;
            left_pulse  <= 1'b0;
        end else begin
            right_shift <= {right_shift[0], right_btn};
            left_shift  <= {left_shift[0], left_btn};
            right_pulse <= right_shift[0] & ~right_shift[1];
            left_pulse  <= left_shift[0] & ~left_shift[1];
        end
    end

    assign start_press = right_pulse | left_pulse;  // Either button starts or restarts

    // Turn latch, restart wins so the starting press never turns
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn <= turn_none;
        end else if (restart) begin
            turn <= turn_none;
        end else if (right_pulse && left_pulse) begin
            turn <= turn_none;                      // Both at once cancels
        end else if (right_pulse) begin
            turn <= turn_right;
        end else if (left_pulse) begin
            turn <= turn_left;
        end else if (step) begin
            turn <= turn_none;                      // Consumed by the move
        end
    end

endmodule

`default_nettype wire

/* snake_ctrl_pkg.sv */
/* Game control types
   FSM state encoding and the latched turn command */

`default_nettype none

package snake_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_wait,
        st_moving,
        st_move_done,
        st_eaten,
        st_fruit_update,
        st_collision
    } game_state_t;

    // Pending turn, relative to the direction of travel
    typedef enum logic [1:0] {
        turn_none,
        turn_left,
        turn_right
    } turn_t;

endpackage

`default_nettype wire

/* snake_geom_pkg.sv */
/* Grid geometry types
   Cell coordinates, heading and body storage of the snake */

`default_nettype none

`include "snake_game_defs.svh"

package snake_geom_pkg;

    // One cell coordinate, wide enough for 0..127
    typedef logic [6:0] coord_t;

    // Up moves toward y = 0
    typedef enum logic [1:0] {
        dir_right,
        dir_left,
        dir_up,
        dir_down
    } dir_t;

    typedef coord_t [`LEN_MAX-1:0] body_array_t;   // Slot 0 is the neck

    typedef logic [`LEN_BITS-1:0] len_t;            // Length counts the head too

endpackage

`default_nettype wire

/* snake_game_defs.svh */
/* Snake game constants
   Grid size, length limits, start positions and fruit LFSR seeds */

`ifndef SNAKE_GAME_DEFS_SVH
`define SNAKE_GAME_DEFS_SVH

// Playfield in cells
`define GRID_W 124
`define GRID_H 81

// Length counter and body storage
`define LEN_BITS 4
`define LEN_MAX 16           // Body slots, also the length ceiling plus one

// Restart position of the head, body trails to the left
`define START_HEAD_X 8
`define START_HEAD_Y 40
`define START_LEN 6          // Head plus five body cells

// First fruit after a restart
`define START_FRUIT_X 8
`define START_FRUIT_Y 42

// Seeds of the two fruit LFSRs
`define SEED_X 7'b0011100
`define SEED_Y 7'b0110000

// Off-grid marker for body slots not in use
`define EMPTY_CELL 127

`endif
